// File: sources.f
+incdir+logic
logic/hart_pkg.sv
logic/stage_reg.sv
logic/fetch.sv
logic/decode.sv
logic/regfile.sv
logic/execute.sv
logic/mem_access.sv
logic/hart.sv
sim/tb_clock.sv
sim/hart_chk.sv
sim/hart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the hart testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module hart_tb \
    -f sources.f \
    -Mdir obj_dir

# The simulator exits non-zero on a fatal check, so keep going to the log search.
./obj_dir/Vhart_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/hart_tb.sv
`timescale 1ns/10ps
`include "hart_config.svh"

module hart_tb import hart_pkg::*; ();
    localparam int    PROG_LEN        = 200;
    localparam int    RETIRE_TIMEOUT  = 40;
    localparam word_t DMEM_BASE       = 32'h0000_0200;
    localparam word_t EBREAK          = 32'h0010_0073;
    localparam word_t RESET_ADDR      = `HART_RESET_ADDR;

    logic      clk;
    logic      rst_n;
    word_t     imem_raddr;
    word_t     imem_rdata;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      dmem_ren;
    logic      dmem_wen;
    logic      retire_valid;
    retire_t   got;
    retire_t   exp;
    word_t     prog [256];
    word_t     dmem [64];
    // architectural state of the reference model
    word_t     mregs [32];
    word_t     mmem [64];
    word_t     model_pc;

    tb_clock #(.PERIOD(40ns)) tb_clock_i (.o_clk(clk));

    hart hart_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
        .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
        .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata),
        .o_retire_valid(retire_valid), .o_retire_inst(got.inst),
        .o_retire_trap(got.trap), .o_retire_halt(got.halt),
        .o_retire_rs1_raddr(got.rs1_raddr), .o_retire_rs2_raddr(got.rs2_raddr),
        .o_retire_rs1_rdata(got.rs1_rdata), .o_retire_rs2_rdata(got.rs2_rdata),
        .o_retire_rd_waddr(got.rd_waddr), .o_retire_rd_wdata(got.rd_wdata),
        .o_retire_pc(got.pc), .o_retire_next_pc(got.next_pc)
    );

    // words past the program decode to an unused opcode
    function automatic word_t imem_word(input word_t addr);
        if (addr < word_t'(PROG_LEN * 4)) begin
            return prog[addr[9:2]];
        end
        return {addr[31:7] ^ addr[24:0], 7'b1111111};
    endfunction

    // every data word starts from a value tied to its full byte address
    function automatic word_t fill_word(input int idx);
        word_t addr;
        addr = DMEM_BASE + word_t'(idx * 4);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    assign imem_rdata = imem_word(imem_raddr);
    // a read only returns data while the hart enables it
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_wen) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // steps the architectural model by one instruction and returns its retire record
    function automatic retire_t model_step(input word_t pc);
        retire_t   r;
        word_t     inst;
        word_t     imm;
        word_t     addr;
        reg_addr_t rs1;
        reg_addr_t rs2;
        inst = prog[pc[9:2]];
        rs1  = inst[19:15];
        rs2  = inst[24:20];
        imm  = {{20{inst[31]}}, inst[31:20]};
        r    = '0;
        r.inst    = inst;
        r.pc      = pc;
        r.next_pc = pc + 32'd4;
        case (inst[6:0])
            7'b0110111, 7'b0010111: begin
                r.rd_waddr = inst[11:7];
                r.rd_wdata = {inst[31:12], 12'b0} + (inst[5] ? 32'd0 : pc);
            end
            7'b0010011: begin
                r.rs1_raddr = rs1;
                r.rs1_rdata = mregs[rs1];
                r.rd_waddr  = inst[11:7];
                r.rd_wdata  = ref_alu(inst[14:12], inst[30] && inst[14:12] == 3'b101,
                                      mregs[rs1], imm);
            end
            7'b0110011: begin
                r.rs1_raddr = rs1;
                r.rs2_raddr = rs2;
                r.rs1_rdata = mregs[rs1];
                r.rs2_rdata = mregs[rs2];
                r.rd_waddr  = inst[11:7];
                r.rd_wdata  = ref_alu(inst[14:12], inst[30], mregs[rs1], mregs[rs2]);
            end
            7'b0000011: begin
                r.rs1_raddr = rs1;
                r.rs1_rdata = mregs[rs1];
                addr        = mregs[rs1] + imm;
                r.trap      = addr[1:0] != 2'b00;
                if (!r.trap) begin
                    r.rd_waddr = inst[11:7];
                    r.rd_wdata = mmem[addr[7:2]];
                end
            end
            7'b0100011: begin
                r.rs1_raddr = rs1;
                r.rs2_raddr = rs2;
                r.rs1_rdata = mregs[rs1];
                r.rs2_rdata = mregs[rs2];
                addr        = mregs[rs1] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                r.trap      = addr[1:0] != 2'b00;
                if (!r.trap) begin
                    mmem[addr[7:2]] = mregs[rs2];
                end
            end
            default: begin
                r.halt = inst == EBREAK;
                r.trap = !r.halt;
            end
        endcase
        if (r.rd_waddr != '0) begin
            mregs[r.rd_waddr] = r.rd_wdata;
        end
        return r;
    endfunction

    // five register inits, a random mix, then ebreak
    task automatic build_program();
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] maddr;
        logic [11:0] imm;
        for (int i = 0; i < 5; i++) begin
            prog[i] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
        end
        for (int i = 5; i < PROG_LEN - 1; i++) begin
            kind  = int'($urandom % 20);
            rd    = 5'(1 + $urandom % 5);
            rs1   = 5'($urandom % 6);
            rs2   = 5'($urandom % 6);
            f3    = 3'($urandom);
            // a handful of word slots so stores and loads meet often
            maddr = 12'(DMEM_BASE + 4 * ($urandom % 8));
            if ($urandom % 8 == 0) begin
                maddr = maddr + 12'(1 + $urandom % 3);
            end
            if (f3 == 3'b001) begin
                imm = {7'b0, 5'($urandom)};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, 1'($urandom), 5'b0, 5'($urandom)};
            end else begin
                imm = 12'($urandom);
            end
            if (kind == 0) begin
                prog[i] = {25'($urandom), 7'b0001111};
            end else if (kind <= 3) begin
                prog[i] = enc_i(maddr, 5'd0, 3'b010, rd, 7'b0000011);
            end else if (kind <= 6) begin
                prog[i] = {maddr[11:5], rs2, 5'd0, 3'b010, maddr[4:0], 7'b0100011};
            end else if (kind == 7) begin
                prog[i] = {20'($urandom), rd, 7'b0110111};
            end else if (kind == 8) begin
                prog[i] = {20'($urandom), rd, 7'b0010111};
            end else if (kind <= 13) begin
                prog[i] = enc_i(imm, rs1, f3, rd, 7'b0010011);
            end else begin
                prog[i] = {((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? 7'h20 : 7'h00,
                           rs2, rs1, f3, rd, 7'b0110011};
            end
        end
        prog[PROG_LEN - 1] = EBREAK;
    endtask

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        while (!retire_valid) begin
            if (cycles >= RETIRE_TIMEOUT) begin
                $display("no instruction retired within %0d cycles", RETIRE_TIMEOUT);
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'hb13e_2043));
        build_program();
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mmem[i] = fill_word(i);
        end
        repeat (8) begin
            @(posedge clk);
            #2;
            check_value("retire valid in reset", word_t'(retire_valid), '0);
            check_value("read enable in reset", word_t'(dmem_ren), '0);
            check_value("write enable in reset", word_t'(dmem_wen), '0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("retire valid after reset", word_t'(retire_valid), '0);
        check_value("read enable after reset", word_t'(dmem_ren), '0);
        check_value("write enable after reset", word_t'(dmem_wen), '0);
        check_value("fetch address after reset", imem_raddr, RESET_ADDR);
        model_pc = RESET_ADDR;
        // one retire is compared per model step at the falling edge
        exp = '0;
        while (!exp.halt) begin
            @(negedge clk);
            wait_retire();
            exp      = model_step(model_pc);
            model_pc = exp.next_pc;
            check_value("retire inst", got.inst, exp.inst);
            check_value("retire pc", got.pc, exp.pc);
            check_value("retire next_pc", got.next_pc, exp.next_pc);
            check_value("retire rs1 addr", word_t'(got.rs1_raddr), word_t'(exp.rs1_raddr));
            check_value("retire rs2 addr", word_t'(got.rs2_raddr), word_t'(exp.rs2_raddr));
            check_value("retire rs1 data", got.rs1_rdata, exp.rs1_rdata);
            check_value("retire rs2 data", got.rs2_rdata, exp.rs2_rdata);
            check_value("retire rd addr", word_t'(got.rd_waddr), word_t'(exp.rd_waddr));
            check_value("retire rd data", got.rd_wdata, exp.rd_wdata);
            check_value("retire trap", word_t'(got.trap), word_t'(exp.trap));
            check_value("retire halt", word_t'(got.halt), word_t'(exp.halt));
        end
        repeat (20) begin
            @(negedge clk);
            check_value("retire after halt", word_t'(retire_valid), '0);
        end
        for (int i = 0; i < 64; i++) begin
            check_value($sformatf("data word %0d", i), dmem[i], mmem[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: sim/hart_chk.sv
`timescale 1ns/10ps

module hart_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic o_dmem_ren,
    input logic o_dmem_wen,
    input logic o_retire_valid,
    input logic o_retire_halt
);
    // set once an ebreak has retired, cleared only by reset
    logic halt_seen;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            halt_seen <= 1'b0;
        end else if (o_retire_valid && o_retire_halt) begin
            halt_seen <= 1'b1;
        end
    end

    // a data access is either a read or a write, never both
    assert property (@(posedge i_clk) !(o_dmem_ren && o_dmem_wen))
        else $error("data memory read and write enabled together");

    // one edge of reset is enough to clear every valid bit
    assert property (@(posedge i_clk) !i_rst_n |=> (!o_dmem_ren && !o_dmem_wen && !o_retire_valid))
        else $error("enable or retire seen while reset was held");

    assert property (@(posedge i_clk) disable iff (!i_rst_n) halt_seen |-> !o_retire_valid)
        else $error("instruction retired after the halting ebreak");

endmodule

bind hart hart_chk hart_chk_i (.*);

// File: sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter realtime PERIOD = 40ns
) (
    output logic o_clk
);
    // starts low so the first rising edge comes half a period in
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

// File: logic/hart.sv
`timescale 1ns/10ps
`include "hart_config.svh"

module hart import hart_pkg::*; #(
    parameter word_t RESET_ADDR = `HART_RESET_ADDR
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    // instruction port, the word comes back in the same cycle
    output word_t     o_imem_raddr,
    input  word_t     i_imem_rdata,
    // data port, reads are combinational and writes land on the next edge
    output word_t     o_dmem_addr,
    output logic      o_dmem_ren,
    output logic      o_dmem_wen,
    output word_t     o_dmem_wdata,
    input  word_t     i_dmem_rdata,
    // retire port, driven straight from the writeback register
    output logic      o_retire_valid,
    output word_t     o_retire_inst,
    output logic      o_retire_trap,
    output logic      o_retire_halt,
    output reg_addr_t o_retire_rs1_raddr,
    output reg_addr_t o_retire_rs2_raddr,
    output word_t     o_retire_rs1_rdata,
    output word_t     o_retire_rs2_rdata,
    output reg_addr_t o_retire_rd_waddr,
    output word_t     o_retire_rd_wdata,
    output word_t     o_retire_pc,
    output word_t     o_retire_next_pc
);
    // fetch to decode
    logic      fe_valid;
    word_t     fe_inst;
    word_t     fe_pc;
    // decode and register file
    logic      de_hold;
    logic      de_halt;
    reg_addr_t rs1_raddr;
    reg_addr_t rs2_raddr;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    // the d side of each stage register is the stage output feeding it
    de_ex_t    de_ex_d;
    de_ex_t    de_ex_q;
    logic      de_ex_valid_d;
    logic      de_ex_valid_q;
    ex_mem_t   ex_mem_d;
    ex_mem_t   ex_mem_q;
    logic      ex_mem_valid;
    mem_wb_t   mem_wb_d;
    mem_wb_t   mem_wb_q;
    logic      mem_wb_valid;

    fetch #(.RESET_ADDR(RESET_ADDR)) fetch_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_hold(de_hold), .i_halt(de_halt),
        .i_imem_rdata(i_imem_rdata), .o_imem_raddr(o_imem_raddr),
        .o_valid(fe_valid), .o_inst(fe_inst), .o_pc(fe_pc)
    );

    // hazard inputs look at what execute and memory access hold right now
    decode decode_i (
        .i_valid(fe_valid), .i_inst(fe_inst), .i_pc(fe_pc),
        .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata),
        .i_ex_load(de_ex_valid_q & de_ex_q.ctrl.mem_read), .i_ex_rd(de_ex_q.rd_waddr),
        .i_ex_mem_rd(ex_mem_d.retire.rd_waddr),
        .i_ex_mem_rd_wen(de_ex_valid_q & ex_mem_d.rd_wen),
        .i_mem_wb_rd(mem_wb_d.rd_waddr), .i_mem_wb_rd_wen(ex_mem_valid),
        .o_rs1_raddr(rs1_raddr), .o_rs2_raddr(rs2_raddr), .o_de_ex(de_ex_d),
        .o_de_ex_valid(de_ex_valid_d), .o_hold(de_hold), .o_halt(de_halt)
    );

    regfile regfile_i (
        .i_clk(i_clk), .i_rs1_raddr(rs1_raddr), .i_rs2_raddr(rs2_raddr),
        .i_rd_wen(mem_wb_valid), .i_rd_waddr(mem_wb_q.rd_waddr),
        .i_rd_wdata(mem_wb_q.rd_wdata),
        .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata)
    );

    stage_reg #(.payload_t(de_ex_t)) de_ex_reg_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(de_ex_valid_d), .i_data(de_ex_d),
        .o_valid(de_ex_valid_q), .o_data(de_ex_q)
    );

    execute execute_i (
        .i_de_ex(de_ex_q), .i_ex_mem_result(ex_mem_q.result),
        .i_mem_wb_rd_wdata(mem_wb_q.rd_wdata), .o_ex_mem(ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(de_ex_valid_q), .i_data(ex_mem_d),
        .o_valid(ex_mem_valid), .o_data(ex_mem_q)
    );

    mem_access mem_access_i (
        .i_ex_mem(ex_mem_q), .i_valid(ex_mem_valid), .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
        .o_dmem_wdata(o_dmem_wdata), .o_mem_wb(mem_wb_d)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(ex_mem_valid), .i_data(mem_wb_d),
        .o_valid(mem_wb_valid), .o_data(mem_wb_q)
    );

    assign o_retire_valid     = mem_wb_valid;
    assign o_retire_inst      = mem_wb_q.inst;
    assign o_retire_trap      = mem_wb_q.trap;
    assign o_retire_halt      = mem_wb_q.halt;
    assign o_retire_rs1_raddr = mem_wb_q.rs1_raddr;
    assign o_retire_rs2_raddr = mem_wb_q.rs2_raddr;
    assign o_retire_rs1_rdata = mem_wb_q.rs1_rdata;
    assign o_retire_rs2_rdata = mem_wb_q.rs2_rdata;
    assign o_retire_rd_waddr  = mem_wb_q.rd_waddr;
    assign o_retire_rd_wdata  = mem_wb_q.rd_wdata;
    assign o_retire_pc        = mem_wb_q.pc;
    assign o_retire_next_pc   = mem_wb_q.next_pc;

endmodule

// File: logic/mem_access.sv
`timescale 1ns/10ps

module mem_access import hart_pkg::*; (
    input  ex_mem_t i_ex_mem,
    input  logic    i_valid,
    input  word_t   i_dmem_rdata,
    output word_t   o_dmem_addr,
    output logic    o_dmem_ren,
    output logic    o_dmem_wen,
    output word_t   o_dmem_wdata,
    output mem_wb_t o_mem_wb
);
    // the alu result of a load or store is its word address
    assign o_dmem_addr  = i_ex_mem.result;
    assign o_dmem_wdata = i_ex_mem.store_data;

    // trapped accesses were already cleared in execute; bubbles stay quiet here
    assign o_dmem_ren = i_valid && i_ex_mem.mem_read;
    assign o_dmem_wen = i_valid && i_ex_mem.mem_write;

    always_comb begin
        o_mem_wb = i_ex_mem.retire;
        if (!i_ex_mem.rd_wen) begin
            // stores, ebreak and traps report no destination at all
            o_mem_wb.rd_waddr = '0;
            o_mem_wb.rd_wdata = '0;
        end else if (i_ex_mem.mem_read) begin
            o_mem_wb.rd_wdata = i_dmem_rdata;
        end else begin
            o_mem_wb.rd_wdata = i_ex_mem.result;
        end
    end

endmodule

// File: logic/execute.sv
`timescale 1ns/10ps
`include "hart_config.svh"

module execute import hart_pkg::*; (
    input  de_ex_t  i_de_ex,
    input  word_t   i_ex_mem_result,
    input  word_t   i_mem_wb_rd_wdata,
    output ex_mem_t o_ex_mem
);
    word_t rs1_val;
    word_t rs2_val;
    word_t src_a;
    word_t src_b;
    word_t result;
    logic  misaligned;
    logic  trap;

    // decode already chose the source, execute only steers the data
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_EX_MEM: return i_ex_mem_result;
            FWD_MEM_WB: return i_mem_wb_rd_wdata;
            default:    return reg_val;
        endcase
    endfunction

    assign rs1_val = fwd_mux(i_de_ex.fwd_rs1, i_de_ex.rs1_rdata);
    assign rs2_val = fwd_mux(i_de_ex.fwd_rs2, i_de_ex.rs2_rdata);
    assign src_a   = i_de_ex.ctrl.use_pc ? i_de_ex.pc : rs1_val;
    assign src_b   = i_de_ex.ctrl.use_imm ? i_de_ex.imm : rs2_val;

    always_comb begin
        case (i_de_ex.ctrl.alu_op)
            ALU_SUB:    result = src_a - src_b;
            ALU_SLL:    result = src_a << src_b[4:0];
            ALU_SLT:    result = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU:   result = word_t'(src_a < src_b);
            ALU_XOR:    result = src_a ^ src_b;
            ALU_SRL:    result = src_a >> src_b[4:0];
            ALU_SRA:    result = word_t'($signed(src_a) >>> src_b[4:0]);
            ALU_OR:     result = src_a | src_b;
            ALU_AND:    result = src_a & src_b;
            ALU_PASS_B: result = src_b;
            default:    result = src_a + src_b;
        endcase
    end

    // only whole-word accesses exist, so both low address bits must be clear
    assign misaligned = (i_de_ex.ctrl.mem_read || i_de_ex.ctrl.mem_write) &&
                        result[1:0] != 2'b00;
    assign trap       = i_de_ex.ctrl.trap || misaligned;

    assign o_ex_mem.retire = '{
        inst:      i_de_ex.inst,
        pc:        i_de_ex.pc,
        next_pc:   i_de_ex.pc + word_t'(`HART_INST_BYTES),
        rs1_raddr: i_de_ex.rs1_raddr,
        rs2_raddr: i_de_ex.rs2_raddr,
        rs1_rdata: rs1_val,
        rs2_rdata: rs2_val,
        rd_waddr:  i_de_ex.rd_waddr,
        rd_wdata:  result,
        trap:      trap,
        halt:      i_de_ex.ctrl.halt
    };
    // a misaligned access neither touches memory nor writes rd
    assign o_ex_mem.mem_read   = i_de_ex.ctrl.mem_read && !misaligned;
    assign o_ex_mem.mem_write  = i_de_ex.ctrl.mem_write && !misaligned;
    assign o_ex_mem.rd_wen     = i_de_ex.ctrl.rd_wen && !misaligned;
    assign o_ex_mem.result     = result;
    assign o_ex_mem.store_data = rs2_val;

endmodule

// File: logic/regfile.sv
`timescale 1ns/10ps
`include "hart_config.svh"

module regfile import hart_pkg::*; (
    input  logic      i_clk,
    input  reg_addr_t i_rs1_raddr,
    input  reg_addr_t i_rs2_raddr,
    input  logic      i_rd_wen,
    input  reg_addr_t i_rd_waddr,
    input  word_t     i_rd_wdata,
    output word_t     o_rs1_rdata,
    output word_t     o_rs2_rdata
);
    // entry 0 is never written and never read
    word_t regs [`HART_NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rd_wen && i_rd_waddr != '0) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    // a write in this cycle is visible to decode right away
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_rd_wen && i_rd_waddr == addr) begin
            return i_rd_wdata;
        end
        return regs[addr];
    endfunction

    assign o_rs1_rdata = read_port(i_rs1_raddr);
    assign o_rs2_rdata = read_port(i_rs2_raddr);

endmodule

// File: logic/decode.sv
`timescale 1ns/10ps

module decode import hart_pkg::*; (
    input  logic      i_valid,
    input  word_t     i_inst,
    input  word_t     i_pc,
    input  word_t     i_rs1_rdata,
    input  word_t     i_rs2_rdata,
    // the load currently in execute
    input  logic      i_ex_load,
    input  reg_addr_t i_ex_rd,
    // the rd that execute and memory access produce this cycle; one clock
    // later they sit in the ex_mem and mem_wb registers
    input  reg_addr_t i_ex_mem_rd,
    input  logic      i_ex_mem_rd_wen,
    input  reg_addr_t i_mem_wb_rd,
    input  logic      i_mem_wb_rd_wen,
    output reg_addr_t o_rs1_raddr,
    output reg_addr_t o_rs2_raddr,
    output de_ex_t    o_de_ex,
    output logic      o_de_ex_valid,
    output logic      o_hold,
    output logic      o_halt
);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    alu_op_t    f3_op;
    ctrl_t      ctrl;
    word_t      imm;
    logic       rs1_used;
    logic       rs2_used;

    assign f3 = i_inst[14:12];
    assign f7 = i_inst[31:25];

    // bit 30 picks sub and sra, but for addi it is just immediate
    assign alt = i_inst[30] && (i_inst[6:0] == OP_REG || f3 == 3'b101);

    always_comb begin
        case (f3)
            3'b000:  f3_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = {{20{i_inst[31]}}, i_inst[31:20]};
        rs1_used    = 1'b0;
        rs2_used    = 1'b0;
        case (opcode_t'(i_inst[6:0]))
            OP_LUI, OP_AUIPC: begin
                // lui passes the immediate, auipc adds it to the pc
                ctrl.alu_op  = (i_inst[6:0] == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                ctrl.use_pc  = (i_inst[6:0] == OP_AUIPC);
                ctrl.use_imm = 1'b1;
                ctrl.rd_wen  = 1'b1;
                imm          = {i_inst[31:12], 12'b0};
            end
            OP_IMM: begin
                ctrl.alu_op  = f3_op;
                ctrl.use_imm = 1'b1;
                ctrl.rd_wen  = 1'b1;
                rs1_used     = 1'b1;
                // shift amounts leave only a narrow choice for the upper bits
                ctrl.trap    = (f3 == 3'b001 && f7 != 7'b0) ||
                               (f3 == 3'b101 && f7 != 7'b0 && f7 != 7'b0100000);
            end
            OP_REG: begin
                ctrl.alu_op = f3_op;
                ctrl.rd_wen = 1'b1;
                rs1_used    = 1'b1;
                rs2_used    = 1'b1;
                ctrl.trap   = f7 != 7'b0 &&
                              !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            end
            OP_LOAD: begin
                ctrl.use_imm  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.rd_wen   = 1'b1;
                rs1_used      = 1'b1;
                ctrl.trap     = f3 != 3'b010;
            end
            OP_STORE: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                rs1_used       = 1'b1;
                rs2_used       = 1'b1;
                imm            = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
                ctrl.trap      = f3 != 3'b010;
            end
            OP_SYSTEM: begin
                ctrl.halt = (i_inst == EBREAK_INST);
                ctrl.trap = !ctrl.halt;
            end
            default: ctrl.trap = 1'b1;
        endcase
        // an illegal word reads nothing and has no side effects
        if (ctrl.trap) begin
            ctrl.rd_wen    = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            rs1_used       = 1'b0;
            rs2_used       = 1'b0;
        end
    end

    assign o_rs1_raddr = rs1_used ? i_inst[19:15] : '0;
    assign o_rs2_raddr = rs2_used ? i_inst[24:20] : '0;

    // the newer result wins when both later stages write the same register
    function automatic fwd_sel_t pick_fwd(input reg_addr_t rs);
        if (rs != '0 && i_ex_mem_rd_wen && rs == i_ex_mem_rd) begin
            return FWD_EX_MEM;
        end
        if (rs != '0 && i_mem_wb_rd_wen && rs == i_mem_wb_rd) begin
            return FWD_MEM_WB;
        end
        return FWD_NONE;
    endfunction

    // load data only exists in the memory stage, so one bubble is needed
    assign o_hold = i_valid && i_ex_load && i_ex_rd != '0 &&
                    (o_rs1_raddr == i_ex_rd || o_rs2_raddr == i_ex_rd);

    assign o_halt        = i_valid && ctrl.halt;
    assign o_de_ex_valid = i_valid && !o_hold;

    assign o_de_ex = '{
        ctrl:      ctrl,
        inst:      i_inst,
        pc:        i_pc,
        rs1_raddr: o_rs1_raddr,
        rs2_raddr: o_rs2_raddr,
        rs1_rdata: i_rs1_rdata,
        rs2_rdata: i_rs2_rdata,
        rd_waddr:  i_inst[11:7],
        imm:       imm,
        fwd_rs1:   pick_fwd(o_rs1_raddr),
        fwd_rs2:   pick_fwd(o_rs2_raddr)
    };

endmodule

// File: logic/fetch.sv
`timescale 1ns/10ps
`include "hart_config.svh"

module fetch import hart_pkg::*; #(
    parameter word_t RESET_ADDR = `HART_RESET_ADDR
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_hold,
    input  logic  i_halt,
    input  word_t i_imem_rdata,
    output word_t o_imem_raddr,
    output logic  o_valid,
    output word_t o_inst,
    output word_t o_pc
);
    word_t pc;
    // sticky once an ebreak reaches decode, only reset clears it
    logic  halted;

    // the pc itself addresses instruction memory
    assign o_imem_raddr = pc;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc      <= RESET_ADDR;
            o_valid <= 1'b0;
            halted  <= 1'b0;
        end else if (i_halt || halted) begin
            // pc freezes and nothing new is issued after the ebreak
            halted  <= 1'b1;
            o_valid <= 1'b0;
        end else if (!i_hold) begin
            pc      <= pc + word_t'(`HART_INST_BYTES);
            o_valid <= 1'b1;
        end
    end

    // the word and its pc stay put while decode waits out a load-use stall
    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            o_inst <= i_imem_rdata;
            o_pc   <= pc;
        end
    end

endmodule

// File: logic/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);
    // valid drops at reset and otherwise follows the upstream stage
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // the payload moves on every edge whether or not it is valid
    always_ff @(posedge i_clk) begin
        o_data <= i_data;
    end

endmodule

// File: logic/hart_pkg.sv
`include "hart_config.svh"

package hart_pkg;

    // plain data or address word
    typedef logic [`HART_XLEN-1:0] word_t;
    // register index, x0 through x31
    typedef logic [4:0] reg_addr_t;

    // major opcodes this hart recognizes; anything else is illegal
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // the only system instruction that executes
    localparam word_t EBREAK_INST = 32'h0010_0073;

    // alu operations; pass-b simply hands the immediate through for lui
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // where execute takes an operand from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_t;

    // decoded control bits carried down the pipe
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    use_pc;
        logic    mem_read;
        logic    mem_write;
        logic    rd_wen;
        logic    trap;
        logic    halt;
    } ctrl_t;

    // everything the retire port reports about one instruction
    typedef struct packed {
        word_t     inst;
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        reg_addr_t rd_waddr;
        word_t     rd_wdata;
        logic      trap;
        logic      halt;
    } retire_t;

    // decode to execute; register data is still unresolved here
    typedef struct packed {
        ctrl_t     ctrl;
        word_t     inst;
        word_t     pc;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        reg_addr_t rd_waddr;
        word_t     imm;
        fwd_sel_t  fwd_rs1;
        fwd_sel_t  fwd_rs2;
    } de_ex_t;

    // execute to memory access; the alu result doubles as the data address
    typedef struct packed {
        retire_t retire;
        logic    mem_read;
        logic    mem_write;
        logic    rd_wen;
        word_t   result;
        word_t   store_data;
    } ex_mem_t;

    // the writeback register holds exactly what retires
    typedef retire_t mem_wb_t;

endpackage

// File: logic/hart_config.svh
`ifndef HART_CONFIG_SVH
`define HART_CONFIG_SVH

// address of the first fetch once reset is released
`define HART_RESET_ADDR 32'h0000_0000

// width of every data word, address and register
`define HART_XLEN 32

// number of architectural registers, x0 included
`define HART_NUM_REGS 32

// every instruction is one word, so the pc always moves by this much
`define HART_INST_BYTES 4

`endif
